// ==== project.f ====
+incdir+verilog
verilog/ofdm_pkg.sv
verilog/sample_fifo.sv
verilog/symbol_timer.sv
verilog/zero_inserter.sv
verilog/ofdm_bin_mapper.sv
testbench/tb_ofdm_bin_mapper.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
    --top-module tb_ofdm_bin_mapper -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1

// ==== testbench/tb_ofdm_bin_mapper.sv ====
`default_nettype none

`include "ofdm_cfg.svh"

module tb_ofdm_bin_mapper;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 1 << `OFDM_FIFO_AW;

    logic                 clk;
    logic                 rst_n;
    logic                 wr_en;
    logic                 enable;
    ofdm_pkg::sample_t    wr_i;
    ofdm_pkg::sample_t    wr_q;
    ofdm_pkg::nfft_log2_t nfft_log2;
    ofdm_pkg::bin_idx_t   nscs;
    ofdm_pkg::cp_len_t    cp_len;
    logic                 full;
    ofdm_pkg::sample_t    out_i;
    ofdm_pkg::sample_t    out_q;
    logic                 out_valid;
    logic                 out_first;
    logic                 underflow;

    ofdm_pkg::sample_t model_i[$];  // written samples in FIFO order
    ofdm_pkg::sample_t model_q[$];
    int cfg_n;
    int cfg_s;
    int cfg_cp;
    int run_id = 0;     // bumped by the stimulus at each run
    int seen_run = -1;  // run of the last symbol start seen at the output
    int bin = 0;
    int sym_seen = 0;
    int gap_cnt = 0;
    int uf_count = 0;

    ofdm_bin_mapper dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_i      (wr_i),
        .wr_q      (wr_q),
        .enable    (enable),
        .nfft_log2 (nfft_log2),
        .nscs      (nscs),
        .cp_len    (cp_len),
        .full      (full),
        .out_i     (out_i),
        .out_q     (out_q),
        .out_valid (out_valid),
        .out_first (out_first),
        .underflow (underflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        stop_on_error($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, want));
    endtask

    // bin k carries data below S/2 or from N-S/2 up
    function automatic bit expected_bin(input int k, input int n, input int s);
        return (k < s / 2) || (k >= n - s / 2);
    endfunction

    task automatic check_bin();
        ofdm_pkg::sample_t exp_i = '0;
        ofdm_pkg::sample_t exp_q = '0;
        logic exp_uf;
        exp_uf = expected_bin(bin, cfg_n, cfg_s);
        if (exp_uf && model_i.size() > 0) begin
            exp_i  = model_i.pop_front();
            exp_q  = model_q.pop_front();
            exp_uf = 1'b0;
        end
        assert (out_i === exp_i) else report_value("out_i", 32'(out_i), 32'(exp_i));
        assert (out_q === exp_q) else report_value("out_q", 32'(out_q), 32'(exp_q));
        assert (underflow === exp_uf) else report_value("underflow", 32'(underflow), 32'(exp_uf));
    endtask

    // output side, follows bins and gaps
    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            if (out_valid === 1'b1) begin
                if (out_first === 1'b1) begin
                    if (seen_run == run_id) begin  // not the first symbol of this run
                        assert (bin == cfg_n - 1) else report_value("bins per symbol", bin + 1, cfg_n);
                        assert (gap_cnt == cfg_cp) else report_value("gap length", gap_cnt, cfg_cp);
                    end
                    seen_run = run_id;
                    bin      = 0;
                    sym_seen++;
                end else begin
                    assert (seen_run == run_id) else stop_on_error("out_valid came before out_first");
                    assert (gap_cnt == 0) else stop_on_error("out_valid dropped inside a symbol");
                    bin++;
                    assert (bin < cfg_n) else stop_on_error("symbol ran longer than N bins");
                end
                gap_cnt = 0;
                if (underflow === 1'b1) uf_count++;
                check_bin();
            end else begin
                assert (out_first !== 1'b1) else stop_on_error("out_first without out_valid");
                assert (underflow !== 1'b1) else stop_on_error("underflow without out_valid");
                gap_cnt++;
            end
        end
    end

    task automatic write_samples(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            assert (full === (model_i.size() == DEPTH))
                else report_value("full", 32'(full), 32'(model_i.size() == DEPTH));
            wr_en = 1'b1;
            wr_i  = ofdm_pkg::sample_t'($urandom);
            wr_q  = ofdm_pkg::sample_t'($urandom);
            if (model_i.size() < DEPTH) begin  // beyond this the write is lost
                model_i.push_back(wr_i);
                model_q.push_back(wr_q);
            end
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic wait_quiet(input int len);
        int quiet = 0;
        int waited = 0;
        while (quiet < len) begin
            @(negedge clk);
            quiet = (out_valid === 1'b1) ? 0 : quiet + 1;
            waited++;
            if (waited > 5000) stop_on_error("timeout waiting for the output to go quiet");
        end
    endtask

    task automatic run_symbols(input int log2n, input int s, input int cp, input int nsym);
        int first_sym = sym_seen;
        int waited = 0;
        @(negedge clk);
        nfft_log2 = ofdm_pkg::nfft_log2_t'(log2n);
        nscs      = ofdm_pkg::bin_idx_t'(s);
        cp_len    = ofdm_pkg::cp_len_t'(cp);
        cfg_n     = 1 << log2n;
        cfg_s     = s;
        cfg_cp    = cp;
        run_id++;
        enable    = 1'b1;
        while (sym_seen - first_sym < nsym) begin
            @(negedge clk);
            waited++;
            if (waited > nsym * (cfg_n + cp) + 20) stop_on_error("timeout waiting for symbols");
        end
        enable = 1'b0;  // timer still finishes the symbol and its gap
        wait_quiet(cp + 4);
        assert (sym_seen - first_sym == nsym) else report_value("symbols", sym_seen - first_sym, nsym);
        assert (bin == cfg_n - 1) else stop_on_error("last symbol ended before bin N-1");
    endtask

    initial begin
        int seed_ret;
        int uf_before;
        seed_ret  = $urandom(64);
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        wr_i      = '0;
        wr_q      = '0;
        enable    = 1'b0;
        nfft_log2 = 4'd6;
        nscs      = 48;
        cp_len    = 16;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (20) begin
            @(negedge clk);
            assert ({out_valid, out_first, underflow, full} === 4'b0)
                else stop_on_error("outputs not quiet while idle after reset");
        end
        write_samples(3 * 48);  // three full symbols of N=64, S=48
        run_symbols(6, 48, 16, 3);
        assert (model_i.size() == 0) else report_value("samples left", model_i.size(), 0);
        write_samples(4 * 8);
        run_symbols(4, 8, 0, 4);  // back to back symbols
        assert (model_i.size() == 0) else report_value("samples left", model_i.size(), 0);
        write_samples(DEPTH + 1);  // last one hits a full FIFO
        run_symbols(6, 64, 8, 4);
        assert (model_i.size() == 0) else report_value("samples left", model_i.size(), 0);
        uf_before = uf_count;
        write_samples(3);  // five occupied bins go short
        run_symbols(4, 8, 4, 1);
        assert (uf_count - uf_before == 5) else report_value("underflows", uf_count - uf_before, 5);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/ofdm_bin_mapper.sv ====
`default_nettype none

`include "ofdm_cfg.svh"

module ofdm_bin_mapper (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 wr_en,
    input  wire ofdm_pkg::sample_t    wr_i,
    input  wire ofdm_pkg::sample_t    wr_q,
    input  wire logic                 enable,
    input  wire ofdm_pkg::nfft_log2_t nfft_log2,
    input  wire ofdm_pkg::bin_idx_t   nscs,
    input  wire ofdm_pkg::cp_len_t    cp_len,
    output logic                      full,
    output ofdm_pkg::sample_t         out_i,
    output ofdm_pkg::sample_t         out_q,
    output logic                      out_valid,
    output logic                      out_first,
    output logic                      underflow
);

    logic              rfd;
    logic              fifo_rd_en;
    logic              fifo_empty;
    ofdm_pkg::sample_t fifo_rd_i;
    ofdm_pkg::sample_t fifo_rd_q;

    // host side sample store
    sample_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (wr_en),
        .wr_i  (wr_i),
        .wr_q  (wr_q),
        .rd_en (fifo_rd_en),
        .rd_i  (fifo_rd_i),
        .rd_q  (fifo_rd_q),
        .empty (fifo_empty),
        .full  (full)
    );

    symbol_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .nfft_log2 (nfft_log2),
        .cp_len    (cp_len),
        .rfd       (rfd)
    );

    // out_valid trails rfd by two cycles
    zero_inserter u_zins (
        .clk        (clk),
        .rst_n      (rst_n),
        .rfd        (rfd),
        .nfft_log2  (nfft_log2),
        .nscs       (nscs),
        .fifo_empty (fifo_empty),
        .rd_i       (fifo_rd_i),
        .rd_q       (fifo_rd_q),
        .rd_en      (fifo_rd_en),
        .out_i      (out_i),
        .out_q      (out_q),
        .out_valid  (out_valid),
        .out_first  (out_first),
        .underflow  (underflow)
    );

endmodule

`default_nettype wire

// ==== verilog/zero_inserter.sv ====
`default_nettype none

`include "ofdm_cfg.svh"

module zero_inserter (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rfd,
    input  wire ofdm_pkg::nfft_log2_t nfft_log2,
    input  wire ofdm_pkg::bin_idx_t   nscs,
    input  wire logic                 fifo_empty,
    input  wire ofdm_pkg::sample_t    rd_i,
    input  wire ofdm_pkg::sample_t    rd_q,
    output logic                      rd_en,
    output ofdm_pkg::sample_t         out_i,
    output ofdm_pkg::sample_t         out_q,
    output logic                      out_valid,
    output logic                      out_first,
    output logic                      underflow
);

    ofdm_pkg::bin_idx_t bin_cnt;

    // band edges, live at bin 0 and held for the rest of the symbol
    ofdm_pkg::bin_idx_t nfft_live, lo_live, hi_live;
    ofdm_pkg::bin_idx_t nfft_q, lo_q, hi_q;
    ofdm_pkg::bin_idx_t nfft_cur, lo_cur, hi_cur;

    logic bin_zero;
    logic bin_last;
    logic occupied;

    // first pipeline stage, one bin behind rfd
    logic s1_valid;
    logic s1_first;
    logic s1_occ;
    logic s1_empty;

    assign bin_zero = (bin_cnt == '0);

    assign nfft_live = ofdm_pkg::bin_idx_t'(1) << nfft_log2;
    assign lo_live   = {1'b0, nscs[`OFDM_BIN_W-1:1]};  // S/2
    assign hi_live   = nfft_live - lo_live;             // N - S/2

    assign nfft_cur = bin_zero ? nfft_live : nfft_q;
    assign lo_cur   = bin_zero ? lo_live : lo_q;
    assign hi_cur   = bin_zero ? hi_live : hi_q;

    assign bin_last = (bin_cnt == nfft_cur - 1'b1);
    assign occupied = (bin_cnt < lo_cur) || (bin_cnt >= hi_cur);

    assign rd_en = rfd && occupied;  // guard bins never touch the FIFO

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bin_cnt <= '0;
        end else if (!rfd || bin_last) begin
            bin_cnt <= '0;   // also wraps for back-to-back symbols
        end else begin
            bin_cnt <= bin_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rfd && bin_zero) begin
            nfft_q <= nfft_live;
            lo_q   <= lo_live;
            hi_q   <= hi_live;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_occ   <= 1'b0;
            s1_empty <= 1'b0;
        end else begin
            s1_valid <= rfd;
            s1_first <= rfd && bin_zero;
            s1_occ   <= rfd && occupied;
            s1_empty <= fifo_empty;  // read ignored if empty was seen here
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_first <= 1'b0;
            underflow <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            out_first <= s1_first;
            underflow <= s1_occ && s1_empty;
        end
    end

    // fifo data lands during stage 1, zero for guard or starved bins
    always_ff @(posedge clk) begin
        if (s1_occ && !s1_empty) begin
            out_i <= rd_i;
            out_q <= rd_q;
        end else begin
            out_i <= '0;
            out_q <= '0;
        end
    end

    a_nscs_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rfd && bin_zero) |-> (!nscs[0] && nscs <= nfft_live)
    );

endmodule

`default_nettype wire

// ==== verilog/symbol_timer.sv ====
`default_nettype none

`include "ofdm_cfg.svh"

module symbol_timer (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 enable,
    input  wire ofdm_pkg::nfft_log2_t nfft_log2,
    input  wire ofdm_pkg::cp_len_t    cp_len,
    output logic                      rfd
);

    ofdm_pkg::timer_state_t state, state_nx;
    ofdm_pkg::bin_idx_t     cnt, cnt_nx;   // cycles left in the current phase minus one
    ofdm_pkg::nfft_log2_t   nfft_log2_q;
    ofdm_pkg::cp_len_t      cp_len_q;
    ofdm_pkg::bin_idx_t     nfft_q;

    assign nfft_q = ofdm_pkg::bin_idx_t'(1) << nfft_log2_q;

    always_comb begin
        state_nx = state;
        cnt_nx   = cnt - 1'b1;
        case (state)
            ofdm_pkg::ST_IDLE: begin
                cnt_nx = cnt;
                if (enable) begin
                    state_nx = ofdm_pkg::ST_BINS;
                    cnt_nx   = (ofdm_pkg::bin_idx_t'(1) << nfft_log2) - 1'b1;
                end
            end
            ofdm_pkg::ST_BINS: begin
                if (cnt == '0) begin
                    if (cp_len_q != '0) begin
                        state_nx = ofdm_pkg::ST_GAP;
                        cnt_nx   = cp_len_q - 1'b1;
                    end else if (enable) begin
                        cnt_nx = nfft_q - 1'b1;  // no gap so the next symbol follows at once
                    end else begin
                        state_nx = ofdm_pkg::ST_IDLE;
                    end
                end
            end
            ofdm_pkg::ST_GAP: begin
                if (cnt == '0) begin
                    state_nx = enable ? ofdm_pkg::ST_BINS : ofdm_pkg::ST_IDLE;
                    cnt_nx   = nfft_q - 1'b1;
                end
            end
            default: state_nx = ofdm_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ofdm_pkg::ST_IDLE;
            cnt   <= '0;
            rfd   <= 1'b0;
        end else begin
            state <= state_nx;
            cnt   <= cnt_nx;
            rfd   <= (state_nx == ofdm_pkg::ST_BINS);
        end
    end

    // config is sampled only on the way out of idle
    always_ff @(posedge clk) begin
        if (state == ofdm_pkg::ST_IDLE && enable) begin
            nfft_log2_q <= nfft_log2;
            cp_len_q    <= cp_len;
        end
    end

    // each burst of rfd starts with a full count of the latched N
    a_bins_start_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(rfd) |-> (cnt == nfft_q - 1'b1)
    );

    a_nfft_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == ofdm_pkg::ST_IDLE && enable) |-> (nfft_log2 <= `OFDM_NFFT_LOG2_MAX)
    );

endmodule

`default_nettype wire

// ==== verilog/sample_fifo.sv ====
`default_nettype none

`include "ofdm_cfg.svh"

module sample_fifo (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              wr_en,
    input  wire ofdm_pkg::sample_t wr_i,
    input  wire ofdm_pkg::sample_t wr_q,
    input  wire logic              rd_en,
    output ofdm_pkg::sample_t      rd_i,
    output ofdm_pkg::sample_t      rd_q,
    output logic                   empty,
    output logic                   full
);

    localparam int DEPTH = 1 << `OFDM_FIFO_AW;

    ofdm_pkg::sample_t mem_i [DEPTH];
    ofdm_pkg::sample_t mem_q [DEPTH];

    // pointers carry one wrap bit above the address
    logic [`OFDM_FIFO_AW:0] wr_ptr;
    logic [`OFDM_FIFO_AW:0] rd_ptr;
    logic [`OFDM_FIFO_AW:0] level;  // entries held

    logic do_wr;
    logic do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`OFDM_FIFO_AW] != rd_ptr[`OFDM_FIFO_AW]) &&
                   (wr_ptr[`OFDM_FIFO_AW-1:0] == rd_ptr[`OFDM_FIFO_AW-1:0]);
    assign level = wr_ptr - rd_ptr;

    assign do_wr = wr_en && !full;   // writes into a full FIFO are dropped
    assign do_rd = rd_en && !empty;  // reads from empty leave rd_ptr alone

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_i[wr_ptr[`OFDM_FIFO_AW-1:0]] <= wr_i;
            mem_q[wr_ptr[`OFDM_FIFO_AW-1:0]] <= wr_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // read data shows up one cycle after rd_en
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_i <= mem_i[rd_ptr[`OFDM_FIFO_AW-1:0]];
            rd_q <= mem_q[rd_ptr[`OFDM_FIFO_AW-1:0]];
        end
    end

    // level above DEPTH would mean a write landed on a full FIFO
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        level[`OFDM_FIFO_AW] |-> (level[`OFDM_FIFO_AW-1:0] == '0)
    );

    // reset leaves the FIFO empty and not full
    a_empty_after_reset: assert property (
        @(posedge clk)
        !rst_n |=> (empty && !full)
    );

endmodule

`default_nettype wire

// ==== verilog/ofdm_pkg.sv ====
`default_nettype none

`include "ofdm_cfg.svh"

package ofdm_pkg;

    typedef logic signed [`OFDM_SAMPLE_W-1:0] sample_t;  // one I or Q value

    typedef logic [`OFDM_BIN_W-1:0] bin_idx_t;  // bin index or subcarrier count

    typedef logic [3:0] nfft_log2_t;

    typedef logic [`OFDM_BIN_W-1:0] cp_len_t;  // gap length in cycles

    // symbol timer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BINS,
        ST_GAP
    } timer_state_t;

endpackage

`default_nettype wire

// ==== verilog/ofdm_cfg.svh ====
`ifndef OFDM_CFG_SVH
`define OFDM_CFG_SVH

// width of one I or Q sample
`define OFDM_SAMPLE_W 16

// largest FFT is 2**11 = 2048 bins
`define OFDM_NFFT_LOG2_MAX 11

// sample FIFO holds 2**8 = 256 I/Q pairs
`define OFDM_FIFO_AW 8

// bin counters need one more bit than the largest log2,
// so that N itself fits and not only N-1
`define OFDM_BIN_W (`OFDM_NFFT_LOG2_MAX + 1)

`endif
